/* Bender.yml */
package:
  name: inst_fetch

sources:
  - rtl/fetch_pkg.sv
  - rtl/sync_queue.sv
  - rtl/bimodal_predictor.sv
  - rtl/jal_predecode.sv
  - rtl/fetch_ctrl.sv
  - rtl/inst_fetch.sv
  - target: test
    files:
      - tests/tb_inst_fetch.sv

/* rtl/bimodal_predictor.sv */
`timescale 1ns/1ps

module bimodal_predictor (
    input  logic                        clk,
    input  logic                        rst,

    // lookup with the current pc
    input  logic [fetch_pkg::addr_w-1:0] pc,
    output logic [fetch_pkg::addr_w-1:0] next_pc,

    // training from the backend
    input  logic                        update_valid,
    input  logic [fetch_pkg::addr_w-1:0] update_pc,
    input  logic                        update_taken,
    input  logic [fetch_pkg::addr_w-1:0] update_target
);

    localparam int entries = 1 << fetch_pkg::pred_index_w;

    logic [1:0]                   counter [entries];
    logic [fetch_pkg::addr_w-1:0] target  [entries];

    logic [fetch_pkg::pred_index_w-1:0] rd_idx;
    logic [fetch_pkg::pred_index_w-1:0] wr_idx;
    logic                               taken;

    // word aligned, so the two low pc bits are skipped
    assign rd_idx = pc[fetch_pkg::pred_index_w+1:2];
    assign wr_idx = update_pc[fetch_pkg::pred_index_w+1:2];

    // upper counter bit set means 2 or 3
    assign taken   = counter[rd_idx][1];
    assign next_pc = taken ? target[rd_idx] : pc + fetch_pkg::addr_w'(4);

    // saturating two-bit counters, start weakly not-taken
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                counter[i] <= 2'b01;
            end
        end else if (update_valid) begin
            if (update_taken && counter[wr_idx] != 2'b11) begin
                counter[wr_idx] <= counter[wr_idx] + 2'd1;
            end else if (!update_taken && counter[wr_idx] != 2'b00) begin
                counter[wr_idx] <= counter[wr_idx] - 2'd1;
            end
        end
    end

    // target is only read once a taken update has written it
    always_ff @(posedge clk) begin
        if (update_valid && update_taken) begin
            target[wr_idx] <= update_target;
        end
    end

endmodule

/* rtl/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                         clk,
    input  logic                         rst,

    // instruction memory request
    output logic                         memreq_valid,
    input  logic                         memreq_ready,
    output logic [fetch_pkg::addr_w-1:0] memreq_addr,

    // instruction memory response, one cycle after the request
    input  logic                         memresp_valid,
    input  logic [fetch_pkg::addr_w-1:0] memresp_addr,
    input  logic [fetch_pkg::inst_w-1:0] memresp_inst,

    // backend redirect
    input  logic                         redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0] redirect_pc,

    // predictor lookup
    output logic [fetch_pkg::addr_w-1:0] pred_pc,
    input  logic [fetch_pkg::addr_w-1:0] pred_next_pc,

    // predecode of the returned word
    input  logic                         jal_is,
    input  logic [fetch_pkg::addr_w-1:0] jal_target,

    // queue side
    input  logic                         space_for_two,
    output logic                         buf_flush,
    output logic                         buf_wvalid,
    output fetch_pkg::fetch_entry_t      buf_wdata
);

    logic [fetch_pkg::addr_w-1:0] pc;
    logic [fetch_pkg::iid_w-1:0]  next_id;

    logic                         run;
    logic                         outstanding;
    logic                         stale;
    logic [fetch_pkg::addr_w-1:0] req_addr;

    logic                         req_fire;
    logic                         resp_ok;
    logic                         jal_follow;

    // one idle cycle after reset before the first request
    assign memreq_valid = run && space_for_two;
    assign memreq_addr  = pc;
    assign pred_pc      = pc;
    assign req_fire     = memreq_valid && memreq_ready;

    // only the response to the live request counts
    assign resp_ok = memresp_valid && outstanding && !stale &&
                     memresp_addr == req_addr;

    assign buf_flush  = redirect_valid;
    assign buf_wvalid = resp_ok && !redirect_valid;
    assign jal_follow = buf_wvalid && jal_is;

    assign buf_wdata.addr    = memresp_addr;
    assign buf_wdata.inst    = memresp_inst;
    assign buf_wdata.inst_id = next_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            next_id     <= '0;
            run         <= 1'b0;
            outstanding <= 1'b0;
            stale       <= 1'b0;
        end else begin
            run <= 1'b1;

            // ids keep counting across redirects
            if (buf_wvalid) begin
                next_id <= next_id + 1'b1;
            end

            if (redirect_valid) begin
                // whatever is in flight is thrown away
                pc          <= redirect_pc;
                outstanding <= 1'b0;
                stale       <= 1'b0;
            end else begin
                if (req_fire) begin
                    outstanding <= 1'b1;
                    // request issued behind a jal fetches the wrong path
                    stale       <= jal_follow;
                end else if (memresp_valid) begin
                    outstanding <= 1'b0;
                    stale       <= 1'b0;
                end

                if (jal_follow) begin
                    pc <= jal_target;
                end else if (req_fire) begin
                    pc <= pred_next_pc;
                end
            end
        end
    end

    // address of the request in flight
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_addr <= pc;
        end
    end

endmodule

/* rtl/fetch_pkg.sv */
package fetch_pkg;

    // datapath widths
    localparam int addr_w = 32;
    localparam int inst_w = 32;

    // instruction id, wraps around
    localparam int iid_w = 8;

    // default depth of the fetch queue
    localparam int queue_depth = 8;

    // bimodal predictor, 64 entries indexed by pc[7:2]
    localparam int pred_index_w = 6;

    // rv32 major opcode of jal
    localparam logic [6:0] opcode_jal = 7'b1101111;

    // one fetched instruction as it sits in the queue
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [inst_w-1:0] inst;
        logic [iid_w-1:0]  inst_id;
    } fetch_entry_t;

endpackage

/* rtl/inst_fetch.sv */
`timescale 1ns/1ps

module inst_fetch (
    input  logic                         clk,
    input  logic                         rst,

    output logic                         memreq_valid,
    input  logic                         memreq_ready,
    output logic [fetch_pkg::addr_w-1:0] memreq_addr,

    input  logic                         memresp_valid,
    input  logic [fetch_pkg::addr_w-1:0] memresp_addr,
    input  logic [fetch_pkg::inst_w-1:0] memresp_inst,

    output logic                         iresp_valid,
    input  logic                         iresp_ready,
    output logic [fetch_pkg::addr_w-1:0] iresp_addr,
    output logic [fetch_pkg::inst_w-1:0] iresp_inst,
    output logic [fetch_pkg::iid_w-1:0]  iresp_inst_id,

    input  logic                         redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0] redirect_pc,

    input  logic                         update_valid,
    input  logic [fetch_pkg::addr_w-1:0] update_pc,
    input  logic                         update_taken,
    input  logic [fetch_pkg::addr_w-1:0] update_target
);

    logic [fetch_pkg::addr_w-1:0] pred_pc;
    logic [fetch_pkg::addr_w-1:0] pred_next_pc;
    logic                         jal_is;
    logic [fetch_pkg::addr_w-1:0] jal_target;

    logic                         space_for_two;
    logic                         buf_flush;
    logic                         buf_wvalid;
    fetch_pkg::fetch_entry_t      buf_wdata;
    fetch_pkg::fetch_entry_t      buf_rdata;

    // queue head straight to the decode side
    assign iresp_addr    = buf_rdata.addr;
    assign iresp_inst    = buf_rdata.inst;
    assign iresp_inst_id = buf_rdata.inst_id;

    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .memreq_valid   (memreq_valid),
        .memreq_ready   (memreq_ready),
        .memreq_addr    (memreq_addr),
        .memresp_valid  (memresp_valid),
        .memresp_addr   (memresp_addr),
        .memresp_inst   (memresp_inst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pred_pc        (pred_pc),
        .pred_next_pc   (pred_next_pc),
        .jal_is         (jal_is),
        .jal_target     (jal_target),
        .space_for_two  (space_for_two),
        .buf_flush      (buf_flush),
        .buf_wvalid     (buf_wvalid),
        .buf_wdata      (buf_wdata)
    );

    jal_predecode u_predecode (
        .inst   (memresp_inst),
        .addr   (memresp_addr),
        .is_jal (jal_is),
        .target (jal_target)
    );

    bimodal_predictor u_pred (
        .clk           (clk),
        .rst           (rst),
        .pc            (pred_pc),
        .next_pc       (pred_next_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target)
    );

    sync_queue #(
        .depth     (fetch_pkg::queue_depth),
        .payload_t (fetch_pkg::fetch_entry_t)
    ) u_queue (
        .clk           (clk),
        .rst           (rst),
        .flush         (buf_flush),
        .wvalid        (buf_wvalid),
        .wdata         (buf_wdata),
        .space_for_two (space_for_two),
        .rvalid        (iresp_valid),
        .rready        (iresp_ready),
        .rdata         (buf_rdata)
    );

endmodule

/* rtl/jal_predecode.sv */
`timescale 1ns/1ps

module jal_predecode (
    input  logic [fetch_pkg::inst_w-1:0] inst,
    input  logic [fetch_pkg::addr_w-1:0] addr,
    output logic                         is_jal,
    output logic [fetch_pkg::addr_w-1:0] target
);

    logic [6:0]                   opcode;
    logic [20:0]                  imm_j;
    logic [fetch_pkg::addr_w-1:0] imm_sext;

    assign opcode = inst[6:0];
    assign is_jal = opcode == fetch_pkg::opcode_jal;

    // j-type immediate, scrambled in the encoding, lsb always zero
    assign imm_j = {
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    assign imm_sext = {{(fetch_pkg::addr_w - 21){imm_j[20]}}, imm_j};

    // pc relative to the jal itself
    assign target = addr + imm_sext;

endmodule

/* rtl/sync_queue.sv */
`timescale 1ns/1ps

module sync_queue #(
    parameter int  depth     = fetch_pkg::queue_depth,
    parameter type payload_t = fetch_pkg::fetch_entry_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,

    input  logic     wvalid,
    input  payload_t wdata,
    output logic     space_for_two,

    output logic     rvalid,
    input  logic     rready,
    output payload_t rdata
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];

    logic [ptr_w-1:0] wptr;
    logic [ptr_w-1:0] rptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             do_write;
    logic             do_read;

    // pointer advance with wrap, depth need not be a power of two
    function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full          = count == cnt_w'(depth);
    assign space_for_two = count <= cnt_w'(depth - 2);

    assign rvalid = count != '0;
    assign rdata  = mem[rptr];

    // a pop frees the slot for a write in the same cycle
    assign do_read  = rvalid && rready && !flush;
    assign do_write = wvalid && !flush && (!full || do_read);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= bump(wptr);
            end
            if (do_read) begin
                rptr <= bump(rptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wptr] <= wdata;
        end
    end

endmodule

/* src.f */
rtl/fetch_pkg.sv
rtl/sync_queue.sv
rtl/bimodal_predictor.sv
rtl/jal_predecode.sv
rtl/fetch_ctrl.sv
rtl/inst_fetch.sv
tests/tb_inst_fetch.sv

/* tests/tb_inst_fetch.sv */
`timescale 1ns/1ps

module tb_inst_fetch;

    // never matches a fetched address
    localparam logic [31:0] no_jump = 32'hffff_ffff;

    logic        clk;
    logic        rst;
    logic        memreq_valid;
    logic        memreq_ready;
    logic [31:0] memreq_addr;
    logic        memresp_valid;
    logic [31:0] memresp_addr;
    logic [31:0] memresp_inst;
    logic        iresp_valid;
    logic        iresp_ready;
    logic [31:0] iresp_addr;
    logic [31:0] iresp_inst;
    logic [7:0]  iresp_inst_id;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        update_valid;
    logic [31:0] update_pc;
    logic        update_taken;
    logic [31:0] update_target;

    logic [31:0]             imem [256];
    fetch_pkg::fetch_entry_t observed [$];
    logic                    mem_fire;
    logic [31:0]             mem_addr_q;
    logic                    stall_q;
    logic                    random_stall;
    integer                  seed;
    int                      errors;
    int                      pass_count;
    int                      fail_count;

    inst_fetch DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // addi-style word, never a jal
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {6'h2b, a[9:2], a[9:0], 1'b0, 7'b0010011};
    endfunction

    // instruction memory, answers one cycle after each accepted request
    always @(posedge clk) begin
        mem_fire   = memreq_valid && memreq_ready && !rst;
        mem_addr_q = memreq_addr;
        stall_q    = random_stall;
        #1;
        memresp_valid = mem_fire;
        memresp_addr  = mem_fire ? mem_addr_q : 32'h0;
        memresp_inst  = mem_fire ? imem[mem_addr_q[9:2]] : 32'h0;
        memreq_ready  = stall_q ? ($random(seed) % 2 != 0) : 1'b1;
    end

    // decode side
    always @(posedge clk) begin
        if (!rst && iresp_valid && iresp_ready) begin
            observed.push_back({iresp_addr, iresp_inst, iresp_inst_id});
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_entries(input string name, input int n, output bit ok);
        int cycles;
        cycles = 0;
        while (observed.size() < n && cycles < 400) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = observed.size() >= n;
        if (!ok) begin
            $display("%s: timed out waiting for %0d entries, only %0d arrived",
                     name, n, observed.size());
            errors++;
        end
    endtask

    // sequential from start, with at most one jump from src to dst
    task automatic check_path(input string name, input int n, input logic [31:0] start,
                              input logic [31:0] src, input logic [31:0] dst);
        logic [31:0] exp_addr;
        bit          ok;
        wait_entries(name, n, ok);
        if (ok) begin
            exp_addr = start;
            for (int k = 0; k < n; k++) begin
                check($sformatf("%s addr %0d", name, k), exp_addr, observed[k].addr);
                check($sformatf("%s inst %0d", name, k), imem[exp_addr[9:2]],
                      observed[k].inst);
                if (k > 0) begin
                    check($sformatf("%s id %0d", name, k),
                          8'(observed[k-1].inst_id + 1), observed[k].inst_id);
                end
                exp_addr = (exp_addr == src) ? dst : exp_addr + 32'd4;
            end
        end
    endtask

    // decode holds off in the redirect cycle, it would be killed too
    task automatic do_redirect(input logic [31:0] target);
        @(posedge clk);
        #1;
        redirect_valid = 1'b1;
        redirect_pc    = target;
        iresp_ready    = 1'b0;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
        iresp_ready    = 1'b1;
        observed.delete();
    endtask

    task automatic apply_update(input logic [31:0] pc, input logic taken,
                                input logic [31:0] target);
        @(posedge clk);
        #1;
        update_valid  = 1'b1;
        update_pc     = pc;
        update_taken  = taken;
        update_target = target;
        @(posedge clk);
        #1;
        update_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic sequential_fetch();
        int start_errors;
        start_errors = errors;
        check_path("sequential fetch", 12, 32'd0, no_jump, 32'd0);
        if (observed.size() > 0) begin
            check("sequential fetch first id", 32'd0, observed[0].inst_id);
        end
        finish_test("sequential fetch", start_errors);
    endtask

    task automatic jal_follow();
        int start_errors;
        start_errors = errors;
        // jal ra, +48 at address 16
        imem[4] = 32'h030000ef;
        do_redirect(32'd0);
        check_path("jal follow", 7, 32'd0, 32'd16, 32'd64);
        foreach (observed[k]) begin
            if (observed[k].addr == 32'd20) begin
                $display("jal follow: an entry from address 20 reached decode");
                errors++;
            end
        end
        imem[4] = fill_word(32'd16);
        finish_test("jal follow", start_errors);
    endtask

    task automatic redirect_stream();
        int start_errors;
        start_errors = errors;
        do_redirect(32'd128);
        check_path("redirect", 12, 32'd128, no_jump, 32'd0);
        finish_test("redirect", start_errors);
    endtask

    task automatic back_pressure();
        int start_errors;
        start_errors = errors;
        do_redirect(32'd256);
        iresp_ready  = 1'b0;
        random_stall = 1'b1;
        repeat (30) @(posedge clk);
        #1;
        check("back pressure memreq_valid", 32'd0, memreq_valid);
        check("back pressure iresp_valid", 32'd1, iresp_valid);
        iresp_ready = 1'b1;
        check_path("back pressure", 20, 32'd256, no_jump, 32'd0);
        random_stall = 1'b0;
        finish_test("back pressure", start_errors);
    endtask

    task automatic prediction();
        int start_errors;
        start_errors = errors;
        apply_update(32'd32, 1'b1, 32'd96);
        apply_update(32'd32, 1'b1, 32'd96);
        do_redirect(32'd0);
        check_path("predict taken", 10, 32'd0, 32'd32, 32'd96);
        apply_update(32'd32, 1'b0, 32'd0);
        apply_update(32'd32, 1'b0, 32'd0);
        do_redirect(32'd0);
        check_path("predict not taken", 10, 32'd0, no_jump, 32'd0);
        finish_test("prediction", start_errors);
    endtask

    initial begin
        seed           = 67;
        errors         = 0;
        pass_count     = 0;
        fail_count     = 0;
        random_stall   = 1'b0;
        rst            = 1'b1;
        memreq_ready   = 1'b1;
        memresp_valid  = 1'b0;
        memresp_addr   = 32'h0;
        memresp_inst   = 32'h0;
        iresp_ready    = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = 32'h0;
        update_valid   = 1'b0;
        update_pc      = 32'h0;
        update_taken   = 1'b0;
        update_target  = 32'h0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = fill_word(32'(i * 4));
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        sequential_fetch();
        jal_follow();
        redirect_stream();
        back_pressure();
        prediction();

        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
